// File: logic/alu_isa_pkg.sv
// opcode and element-width enums, opcode classification helpers
`default_nettype none

package alu_isa_pkg;

   typedef enum logic [3:0] {
      op_add,                                // a + b
      op_sub,                                // a - b
      op_and,
      op_or,
      op_xor,
      op_slt,                                // set-compares, result is 0 or 1
      op_sltu,
      op_sle,
      op_sleu,
      op_sgt,
      op_sgtu,
      op_seq,
      op_sne,
      op_mul,                                // low half of product
      op_mulh,                               // high half, signed x signed
      op_mulhu                               // high half, unsigned x unsigned
   } alu_op_e;

   typedef enum logic [1:0] {
      sew_8  = 2'd0,
      sew_16 = 2'd1,
      sew_32 = 2'd2
   } sew_e;

   function automatic logic is_compare(input alu_op_e op);
      return op inside {op_slt, op_sltu, op_sle, op_sleu, op_sgt, op_sgtu, op_seq, op_sne};
   endfunction

   function automatic logic is_signed_op(input alu_op_e op);
      return op inside {op_slt, op_sle, op_sgt, op_mulh, op_add, op_sub, op_mul}; // sign-extend
   endfunction

   function automatic logic is_mul_high(input alu_op_e op);
      return op inside {op_mulh, op_mulhu};
   endfunction

endpackage

`default_nettype wire

// File: logic/alu_datapath_pkg.sv
// lane data width, product width and pipeline depth constants
`default_nettype none

package alu_datapath_pkg;

   // operand and result width of one lane
   localparam int LANE_DATA_W = 32;

   localparam int LANE_PROD_W = 2 * LANE_DATA_W;  // full product / sum width

   // valid_i at edge k gives valid_o after edge k+4
   localparam int PIPE_DEPTH = 4;

endpackage

`default_nettype wire

// File: logic/alu_lane_ifs.sv
// operand bus and arith-to-result stage bus with source and sink modports
`timescale 1ns/100ps
`default_nettype none

interface operand_if #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
);
   import alu_isa_pkg::*;

   logic              valid;                 // qualifies the rest
   alu_op_e           op;
   sew_e              sew;
   logic [DATA_W-1:0] a;                     // extended first operand
   logic [DATA_W-1:0] b;                     // extended second operand

   modport src (output valid, op, sew, a, b);
   modport snk (input valid, op, sew, a, b);
endinterface

interface stage_if #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
);
   import alu_isa_pkg::*;

   logic                valid;
   alu_op_e             op;
   sew_e                sew;
   logic [2*DATA_W-1:0] value;               // product or sum, full width

   modport src (output valid, op, sew, value);
   modport snk (input valid, op, sew, value);
endinterface

`default_nettype wire

// File: logic/operand_stage.sv
// input register stage with element-width extension of both operands
`timescale 1ns/100ps
`default_nettype none

module operand_stage #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 valid_i,
   input  alu_isa_pkg::alu_op_e op_i,
   input  alu_isa_pkg::sew_e    sew_i,
   input  logic [DATA_W-1:0]    op1_i,
   input  logic [DATA_W-1:0]    op2_i,
   operand_if.src               opnd
);
   import alu_isa_pkg::*;

   logic              valid_q;
   alu_op_e           op_q;
   sew_e              sew_q;
   logic [DATA_W-1:0] op1_q;
   logic [DATA_W-1:0] op2_q;
   logic              sgn;                   // sign-extend when set, else zero-extend

   // widen the low element of x to DATA_W bits
   function automatic logic [DATA_W-1:0] extend(input logic [DATA_W-1:0] x,
                                                input sew_e sew,
                                                input logic sign);
      logic [DATA_W-1:0] r;
      r = x;
      case (sew)
         sew_8:   r = {{(DATA_W-8){sign & x[7]}}, x[7:0]};
         sew_16:  r = {{(DATA_W-16){sign & x[15]}}, x[15:0]};
         default: r = x;                     // full width, nothing to extend
      endcase
      return r;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         valid_q <= 1'b0;
         op_q    <= op_add;
         sew_q   <= sew_8;
      end
      else
      begin
         valid_q <= valid_i;
         op_q    <= op_i;
         sew_q   <= sew_i;
      end
   end

   always_ff @(posedge clk)
   begin
      op1_q <= op1_i;                        // operands are payload, taken every cycle
      op2_q <= op2_i;
   end

   assign sgn = is_signed_op(op_q);

   assign opnd.valid = valid_q;
   assign opnd.op    = op_q;
   assign opnd.sew   = sew_q;
   assign opnd.a     = extend(op1_q, sew_q, sgn);
   assign opnd.b     = extend(op2_q, sew_q, sgn);

endmodule

`default_nettype wire

// File: logic/compare_unit.sv
// set-compare evaluation on extended operands and its two-cycle alignment delay
`timescale 1ns/100ps
`default_nettype none

module compare_unit #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
) (
   input  logic   clk,
   input  logic   rstn,
   operand_if.snk opnd,
   output logic   flag_o
);
   import alu_isa_pkg::*;

   logic       lt_s;                         // a < b, signed
   logic       lt_u;                         // a < b, unsigned
   logic       eq;
   logic       flag_d;
   logic [1:0] flag_q;                       // [0] lines up with arith input reg, [1] with value

   assign lt_s = $signed(opnd.a) < $signed(opnd.b);
   assign lt_u = opnd.a < opnd.b;
   assign eq   = opnd.a == opnd.b;

   always_comb
   begin
      flag_d = 1'b0;                         // non-compare ops give 0
      case (opnd.op)
         op_slt:  flag_d = lt_s;
         op_sltu: flag_d = lt_u;
         op_sle:  flag_d = lt_s | eq;
         op_sleu: flag_d = lt_u | eq;
         op_sgt:  flag_d = ~(lt_s | eq);
         op_sgtu: flag_d = ~(lt_u | eq);
         op_seq:  flag_d = eq;
         op_sne:  flag_d = ~eq;
         default: flag_d = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
         flag_q <= 2'b00;
      else
         flag_q <= {flag_q[0], flag_d & opnd.valid}; // only valid compares raise the flag
   end

   assign flag_o = flag_q[1];

endmodule

`default_nettype wire

// File: logic/arith_unit.sv
// behavioral add/logic/multiply datapath with input and product registers
`timescale 1ns/100ps
`default_nettype none

module arith_unit #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
) (
   input  logic   clk,
   input  logic   rstn,
   operand_if.snk opnd,
   stage_if.src   stg
);
   import alu_isa_pkg::*;

   localparam int PROD_W = 2 * DATA_W;

   // input register stage, like the A/B regs of a DSP slice
   logic              in_valid_q;
   alu_op_e           in_op_q;
   sew_e              in_sew_q;
   logic [DATA_W-1:0] a_q;
   logic [DATA_W-1:0] b_q;

   // product/sum register stage
   logic              valid_q;
   alu_op_e           op_q;
   sew_e              sew_q;
   logic [PROD_W-1:0] value_q;

   logic              sgn;
   logic [PROD_W-1:0] a_w;                   // operands widened to product width
   logic [PROD_W-1:0] b_w;
   logic [PROD_W-1:0] value_d;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         in_valid_q <= 1'b0;
         in_op_q    <= op_add;
         in_sew_q   <= sew_8;
         valid_q    <= 1'b0;
         op_q       <= op_add;
         sew_q      <= sew_8;
      end
      else
      begin
         in_valid_q <= opnd.valid;
         in_op_q    <= opnd.op;
         in_sew_q   <= opnd.sew;
         valid_q    <= in_valid_q;
         op_q       <= in_op_q;
         sew_q      <= in_sew_q;
      end
   end

   always_ff @(posedge clk)
   begin
      a_q     <= opnd.a;
      b_q     <= opnd.b;
      value_q <= value_d;
   end

   assign sgn = is_signed_op(in_op_q);       // mulh signed, mulhu unsigned
   assign a_w = {{DATA_W{sgn & a_q[DATA_W-1]}}, a_q};
   assign b_w = {{DATA_W{sgn & b_q[DATA_W-1]}}, b_q};

   always_comb
   begin
      value_d = '0;                          // compares do not use the value
      case (in_op_q)
         op_add:                   value_d = {{DATA_W{1'b0}}, a_q + b_q}; // wraps at DATA_W
         op_sub:                   value_d = {{DATA_W{1'b0}}, a_q - b_q};
         op_and:                   value_d = {{DATA_W{1'b0}}, a_q & b_q};
         op_or:                    value_d = {{DATA_W{1'b0}}, a_q | b_q};
         op_xor:                   value_d = {{DATA_W{1'b0}}, a_q ^ b_q};
         op_mul, op_mulh, op_mulhu: value_d = a_w * b_w; // low PROD_W bits, two's complement
         default:                  value_d = '0;
      endcase
   end

   assign stg.valid = valid_q;
   assign stg.op    = op_q;
   assign stg.sew   = sew_q;
   assign stg.value = value_q;

endmodule

`default_nettype wire

// File: logic/result_stage.sv
// result merge, multiply high-half selection and output register
`timescale 1ns/100ps
`default_nettype none

module result_stage #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
) (
   input  logic              clk,
   input  logic              rstn,
   stage_if.snk              stg,
   input  logic              flag_i,
   output logic              valid_o,
   output logic [DATA_W-1:0] result_o
);
   import alu_isa_pkg::*;

   logic [DATA_W-1:0] result_d;
   logic [DATA_W-1:0] result_q;
   logic              valid_q;

   always_comb
   begin
      if (is_compare(stg.op))
         result_d = {{(DATA_W-1){1'b0}}, flag_i};     // set result, 0 or 1
      else if (is_mul_high(stg.op))
      begin
         case (stg.sew)                               // bits SEW..2*SEW-1 of element product
            sew_8:   result_d = {{(DATA_W-8){1'b0}}, stg.value[15:8]};
            sew_16:  result_d = {{(DATA_W-16){1'b0}}, stg.value[31:16]};
            default: result_d = stg.value[2*DATA_W-1:DATA_W];
         endcase
      end
      else
         result_d = stg.value[DATA_W-1:0];            // sum, logic or low product
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
         valid_q <= 1'b0;
      else
         valid_q <= stg.valid;
   end

   always_ff @(posedge clk)
   begin
      result_q <= result_d;
   end

   assign valid_o  = valid_q;
   assign result_o = result_q;

endmodule

`default_nettype wire

// File: logic/alu_lane_top.sv
// vector ALU lane top level wiring the operand, compare, arith and result stages
`timescale 1ns/100ps
`default_nettype none

module alu_lane_top #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 valid_i,
   input  alu_isa_pkg::alu_op_e op_i,
   input  alu_isa_pkg::sew_e    sew_i,
   input  logic [DATA_W-1:0]    op1_i,
   input  logic [DATA_W-1:0]    op2_i,
   output logic                 valid_o,
   output logic [DATA_W-1:0]    result_o
);

   operand_if #(.DATA_W(DATA_W)) opnd_bus ();  // edge k+1 onwards
   stage_if   #(.DATA_W(DATA_W)) stg_bus ();   // edge k+3 onwards

   logic cmp_flag;                             // aligned with stg_bus.value

   operand_stage #(.DATA_W(DATA_W)) u_operand_stage (
      .clk     (clk),
      .rstn    (rstn),
      .valid_i (valid_i),
      .op_i    (op_i),
      .sew_i   (sew_i),
      .op1_i   (op1_i),
      .op2_i   (op2_i),
      .opnd    (opnd_bus.src)
   );

   compare_unit #(.DATA_W(DATA_W)) u_compare_unit (
      .clk    (clk),
      .rstn   (rstn),
      .opnd   (opnd_bus.snk),
      .flag_o (cmp_flag)
   );

   arith_unit #(.DATA_W(DATA_W)) u_arith_unit (
      .clk  (clk),
      .rstn (rstn),
      .opnd (opnd_bus.snk),
      .stg  (stg_bus.src)
   );

   result_stage #(.DATA_W(DATA_W)) u_result_stage (
      .clk      (clk),
      .rstn     (rstn),
      .stg      (stg_bus.snk),
      .flag_i   (cmp_flag),
      .valid_o  (valid_o),
      .result_o (result_o)
   );

endmodule

`default_nettype wire

// File: verification/alu_lane_chk.sv
// lane latency, reset and compare-range assertions, bound into the lane top
`timescale 1ns/100ps
`default_nettype none

module alu_lane_chk #(
   parameter int DATA_W = alu_datapath_pkg::LANE_DATA_W
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 valid_i,
   input  alu_isa_pkg::alu_op_e op_i,
   input  logic                 valid_o,
   input  logic [DATA_W-1:0]    result_o
);
   import alu_isa_pkg::*;
   import alu_datapath_pkg::*;

   int unsigned fail_count = 0;                // number of failed assertions

   valid_latency: assert property (@(posedge clk) disable iff (!rstn)
      valid_o == $past(valid_i, PIPE_DEPTH))   // one result per input, fixed delay
   else
   begin
      $error("valid_o does not follow valid_i by %0d cycles", PIPE_DEPTH);
      fail_count++;
   end

   // low reset, and the cycle right after release, keep the output quiet
   reset_quiet: assert property (@(posedge clk) (!rstn || !$past(rstn)) |=> !valid_o)
   else
   begin
      $error("valid_o high during reset or on the cycle after");
      fail_count++;
   end

   compare_is_bit: assert property (@(posedge clk) disable iff (!rstn)
      valid_o && is_compare($past(op_i, PIPE_DEPTH)) |-> result_o[DATA_W-1:1] == '0)
   else
   begin
      $error("compare result wider than one bit");
      fail_count++;
   end

endmodule

bind alu_lane_top alu_lane_chk #(.DATA_W(DATA_W)) u_lane_chk (
   .clk      (clk),
   .rstn     (rstn),
   .valid_i  (valid_i),
   .op_i     (op_i),
   .valid_o  (valid_o),
   .result_o (result_o)
);

`default_nettype wire

// File: verification/alu_lane_tb.sv
// lane testbench with clock, reset, directed and random tests, reference model and result check
`timescale 1ns/100ps
`default_nettype none

module alu_lane_tb;
   import alu_isa_pkg::*;
   import alu_datapath_pkg::*;

   // reset, latency test, logic ops, compares, multiplies, 200-op stream with gaps and drains
   localparam int RUN_CYCLES = 5 + 20 + 40 + 80 + 44 + 260;

   logic        clk;
   logic        rstn;
   logic        valid_i;
   alu_op_e     op_i;
   sew_e        sew_i;
   logic [31:0] op1_i;
   logic [31:0] op2_i;
   logic        valid_o;
   logic [31:0] result_o;

   alu_op_e     hist_op [PIPE_DEPTH];        // inputs as the DUT took them, oldest last
   sew_e        hist_sew [PIPE_DEPTH];
   logic [31:0] hist_a [PIPE_DEPTH];
   logic [31:0] hist_b [PIPE_DEPTH];
   logic [31:0] exp_result;
   int          errors = 0;
   int          n_in = 0;                    // valid inputs sent
   int          n_out = 0;                   // valid results seen
   int          tests = 0;

   alu_lane_top #(.DATA_W(LANE_DATA_W)) UUT (
      .clk      (clk),
      .rstn     (rstn),
      .valid_i  (valid_i),
      .op_i     (op_i),
      .sew_i    (sew_i),
      .op1_i    (op1_i),
      .op2_i    (op2_i),
      .valid_o  (valid_o),
      .result_o (result_o)
   );

   always #4 clk = ~clk;                     // 8 ns period

   function automatic logic [31:0] elem_mask(input sew_e sew);
      case (sew)
         sew_8:   return 32'h0000_00ff;
         sew_16:  return 32'h0000_ffff;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   // expected lane result from the opcode and width rules
   function automatic logic [31:0] ref_result(input alu_op_e op, input sew_e sew,
                                              input logic [31:0] x, input logic [31:0] y);
      logic [31:0] m;
      logic [31:0] ea;
      logic [31:0] eb;
      logic [63:0] p;
      int          ew;
      logic        sgn;
      m   = elem_mask(sew);
      ew  = $countones(m);
      sgn = op inside {op_add, op_sub, op_mul, op_mulh, op_slt, op_sle, op_sgt};
      ea  = (x & m) | ((sgn && x[ew-1]) ? ~m : 32'd0);  // sign or zero fill above element
      eb  = (y & m) | ((sgn && y[ew-1]) ? ~m : 32'd0);
      if (sgn)
         p = $signed({{32{ea[31]}}, ea}) * $signed({{32{eb[31]}}, eb});
      else
         p = {32'd0, ea} * {32'd0, eb};
      case (op)
         op_add:  return ea + eb;
         op_sub:  return ea - eb;
         op_and:  return ea & eb;
         op_or:   return ea | eb;
         op_xor:  return ea ^ eb;
         op_slt:  return {31'd0, $signed(ea) < $signed(eb)};
         op_sltu: return {31'd0, ea < eb};
         op_sle:  return {31'd0, $signed(ea) <= $signed(eb)};
         op_sleu: return {31'd0, ea <= eb};
         op_sgt:  return {31'd0, $signed(ea) > $signed(eb)};
         op_sgtu: return {31'd0, ea > eb};
         op_seq:  return {31'd0, ea == eb};
         op_sne:  return {31'd0, ea != eb};
         op_mul:  return p[31:0];
         default: return 32'((p >> ew) & {32'd0, m});  // mulh and mulhu, high element half
      endcase
   endfunction

   always @(posedge clk)
   begin
      hist_op[0]  <= op_i;                   // same values the operand stage captures
      hist_sew[0] <= sew_i;
      hist_a[0]   <= op1_i;
      hist_b[0]   <= op2_i;
      for (int i = 1; i < PIPE_DEPTH; i++)
      begin
         hist_op[i]  <= hist_op[i-1];
         hist_sew[i] <= hist_sew[i-1];
         hist_a[i]   <= hist_a[i-1];
         hist_b[i]   <= hist_b[i-1];
      end
      if (rstn && valid_o)
         n_out <= n_out + 1;
   end

   assign exp_result = ref_result(hist_op[PIPE_DEPTH-1], hist_sew[PIPE_DEPTH-1],
                                  hist_a[PIPE_DEPTH-1], hist_b[PIPE_DEPTH-1]);

   result_matches: assert property (@(posedge clk) disable iff (!rstn)
      valid_o |-> result_o == exp_result)
   else
   begin
      $display("mismatch at %0t ns: result_o expected %h actual %h", $time,
               $sampled(exp_result), $sampled(result_o));
      errors++;
   end

   task automatic send_op(input logic v, input alu_op_e op, input sew_e sew,
                          input logic [31:0] a, input logic [31:0] b);
      @(posedge clk);
      valid_i <= v;
      op_i    <= op;
      sew_i   <= sew;
      op1_i   <= a;
      op2_i   <= b;
      if (v)
         n_in++;
   endtask

   // stop driving and wait until every sent op has come back
   task automatic drain_results(input string name);
      int waited;
      waited = 0;
      @(posedge clk);
      valid_i <= 1'b0;
      while (n_out != n_in && waited < 4 * PIPE_DEPTH)
      begin
         @(posedge clk);
         waited++;
      end
      if (n_out != n_in)
      begin
         $display("%s: %0d results came back for %0d valid inputs", name, n_out, n_in);
         errors++;
      end
      tests++;
      $display("test %s done, errors so far %0d", name, errors);
   endtask

   initial
   begin
      logic [31:0] hi;
      logic [31:0] neg;
      logic [31:0] pos;
      sew_e        s;
      void'($urandom(32'hd4a1));             // single seed for the run
      clk     = 1'b0;
      rstn    = 1'b0;
      valid_i = 1'b0;
      op_i    = op_add;
      sew_i   = sew_32;
      op1_i   = '0;
      op2_i   = '0;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;

      repeat (8) @(posedge clk);             // quiet pipe after reset
      send_op(1'b1, op_add, sew_32, $urandom, $urandom);
      drain_results("reset_latency");

      for (int o = op_add; o <= op_xor; o++)
      begin
         repeat (6) send_op(1'b1, alu_op_e'(4'(o)), sew_32, $urandom, $urandom);
         send_op(1'b1, alu_op_e'(4'(o)), sew_32, 32'hffff_ff00 | $urandom,
                 32'hffff_ff00 | $urandom);
      end
      drain_results("logic_sew32");

      for (int w = 0; w < 3; w++)
      begin
         s   = sew_e'(2'(w));
         hi  = elem_mask(s) ^ (elem_mask(s) >> 1);   // top bit of the element
         neg = $urandom | hi;
         pos = $urandom & ~hi;
         for (int o = op_slt; o <= op_sne; o++)
         begin
            send_op(1'b1, alu_op_e'(4'(o)), s, neg, pos);
            send_op(1'b1, alu_op_e'(4'(o)), s, pos, neg);
            send_op(1'b1, alu_op_e'(4'(o)), s, neg, neg);  // equal elements
         end
      end
      drain_results("set_compare");

      for (int w = 0; w < 3; w++)
      begin
         s  = sew_e'(2'(w));
         hi = elem_mask(s) ^ (elem_mask(s) >> 1);
         for (int o = op_mul; o <= op_mulhu; o++)
         begin
            repeat (3) send_op(1'b1, alu_op_e'(4'(o)), s, $urandom, $urandom);
            send_op(1'b1, alu_op_e'(4'(o)), s, $urandom | hi, $urandom | hi);
         end
      end
      drain_results("multiply");

      for (int i = 0; i < 200; i++)
      begin
         if ($urandom % 8 == 0)
            send_op(1'b0, op_add, sew_32, 32'd0, 32'd0);     // gap in the stream
         send_op(1'b1, alu_op_e'(4'($urandom)), sew_e'(2'($urandom_range(2, 0))),
                 $urandom, $urandom);
      end
      drain_results("random_stream");

      errors += UUT.u_lane_chk.fail_count;   // bound latency, reset and range checks
      $display("%0d tests, %0d results checked, %0d errors", tests, n_out, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   initial
   begin
      repeat (RUN_CYCLES + 100) @(posedge clk);
      $display("watchdog expired after %0d cycles, tests did not finish", RUN_CYCLES + 100);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: alu_lane_top.f
logic/alu_isa_pkg.sv
logic/alu_datapath_pkg.sv
logic/alu_lane_ifs.sv
logic/operand_stage.sv
logic/compare_unit.sv
logic/arith_unit.sv
logic/result_stage.sv
logic/alu_lane_top.sv
verification/alu_lane_chk.sv
verification/alu_lane_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the ALU lane testbench with Verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module alu_lane_tb -f alu_lane_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Valu_lane_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
   exit 0
fi
exit 1
